/* project.f */
dma_probe_pkg.sv
dmem_ram.sv
dma_probe_trace.sv
dmem_arbiter.sv
dma_probe_master.sv
dma_probe_regs.sv
dma_probe_top.sv
tb_dma_probe.sv

/* Makefile */
# Verilator flow for the DMA timing probe
TB_TOP := tb_dma_probe

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module dma_probe_top
	verilator --lint-only --timing -f project.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP) \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_dma_probe.sv */
`timescale 1ns/1ps

module tb_dma_probe;

  // ======================================================================
  // Cycle budgets, clock and DUT
  // ======================================================================

  // Cycles per test summed for the watchdog
  localparam int CYC_RESET  = 10;
  localparam int CYC_FILL   = 260;
  localparam int CYC_REGS   = 40;
  localparam int CYC_WRITE  = 60;
  localparam int CYC_READ   = 50;
  localparam int CYC_STALL  = 180;
  localparam int CYC_CANCEL = 60;
  localparam int CYC_ZERO   = 20;
  localparam int WATCHDOG_CYC = 2 * (CYC_RESET + CYC_FILL + CYC_REGS + CYC_WRITE +
                                     CYC_READ + CYC_STALL + CYC_CANCEL + CYC_ZERO);

  // Word address of CNTRL1 and CNTRL2
  // CNTRL3 and CNTRL4 sit one word up
  localparam logic [13:0] CTRL_WORD = dma_probe_pkg::BASE_ADDR[14:1];

  logic        mclk;
  logic        puc_rst;
  logic [13:0] per_addr;
  logic [15:0] per_din;
  logic        per_en;
  logic [1:0]  per_we;
  logic [15:0] per_dout;
  logic        cpu_en;
  logic [7:0]  cpu_addr;
  logic [1:0]  cpu_we;
  logic [15:0] cpu_din;
  logic [15:0] cpu_dout;
  logic        dma_tfx_cancel;
  logic        dma_en;
  logic        dma_busy;
  logic [7:0]  dma_rdata;
  logic [15:0] trace;

  // Expected memory, control bytes and grant history
  logic [15:0] mem_model [256];
  logic [7:0]  reg_model [4];
  logic [15:0] exp_trace;
  logic [31:0] lfsr;

  dma_probe_top dut0 (.*);

  initial begin
    mclk = 1'b0;
    forever #50 mclk = ~mclk;
  end

  // ======================================================================
  // Helpers
  // ======================================================================

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // All bus tasks start and end 5 ns after a rising edge
  task automatic per_write(input logic [13:0] addr, input logic [1:0] we,
                           input logic [15:0] din);
    per_addr = addr;
    per_din  = din;
    per_we   = we;
    per_en   = 1'b1;
    @(posedge mclk);
    #5;
    per_en = 1'b0;
    per_we = 2'b00;
    for (int l = 0; l < 2; l++) begin
      if (we[l] && addr[13:1] == CTRL_WORD[13:1])
        reg_model[{addr[0], 1'(l)}] = din[8*l +: 8];
    end
    // Start is a strobe only
    reg_model[0][0] = 1'b0;
  endtask

  // Combinational read data sampled mid-cycle
  task automatic per_read(input logic [13:0] addr, output logic [15:0] dout);
    per_addr = addr;
    per_we   = 2'b00;
    per_en   = 1'b1;
    #20;
    dout = per_dout;
    @(posedge mclk);
    #5;
    per_en = 1'b0;
  endtask

  task automatic cpu_write(input logic [7:0] addr, input logic [15:0] din);
    cpu_addr = addr;
    cpu_din  = din;
    cpu_we   = 2'b11;
    cpu_en   = 1'b1;
    @(posedge mclk);
    #5;
    cpu_en = 1'b0;
    cpu_we = 2'b00;
    mem_model[addr] = din;
  endtask

  // Registered memory output valid after the edge
  task automatic cpu_read(input logic [7:0] addr, output logic [15:0] dout);
    cpu_addr = addr;
    cpu_we   = 2'b00;
    cpu_en   = 1'b1;
    @(posedge mclk);
    #5;
    cpu_en = 1'b0;
    dout   = cpu_dout;
  endtask

  task automatic verify_memory(input logic [7:0] lo, input int n);
    logic [15:0] rd;
    for (int i = 0; i < n; i++) begin
      cpu_read(lo + 8'(i), rd);
      check("cpu_dout", rd, mem_model[lo + 8'(i)]);
    end
  endtask

  // Trace shifts dma_en and not cpu_en on every edge while running
  always @(negedge mclk) begin
    if (!puc_rst) begin
      check("trace", trace, exp_trace);
      if (dma_busy || reg_model[0][2])
        exp_trace = {exp_trace[14:0], dma_en & ~cpu_en};
    end
  end

  // ======================================================================
  // Burst driver and checker
  // ======================================================================

  // cancel_at is the loop cycle that raises cancel
  // A negative cancel_at means no cancel
  task automatic run_burst(input logic dir, input logic [7:0] addr, input logic [7:0] data,
                           input logic [7:0] count, input logic stall, input int cancel_at);
    int         grants;
    int         cyc;
    logic       busy;
    logic       grant;
    logic       rd_next;
    logic       rd_due;
    logic [7:0] rd_next_addr;
    logic [7:0] rd_due_addr;
    grants       = 0;
    cyc          = 0;
    rd_next      = 1'b0;
    rd_due       = 1'b0;
    rd_next_addr = 8'h00;
    rd_due_addr  = 8'h00;
    per_write(CTRL_WORD + 14'd1, 2'b11, {count, data});
    per_write(CTRL_WORD, 2'b11, {addr, 6'b000000, dir, 1'b1});
    // Request up two edges after the start write
    @(posedge mclk);
    #5;
    busy = (count != 8'd0);
    check("dma_en", 16'(dma_en), 16'(busy));
    check("dma_busy", 16'(dma_busy), 16'(busy));
    while (busy || rd_due || rd_next) begin
      // Read byte lands one cycle after its grant
      if (rd_due)
        check("dma_rdata", 16'(dma_rdata), 16'(mem_model[rd_due_addr][7:0]));
      rd_due         = rd_next;
      rd_due_addr    = rd_next_addr;
      cpu_en         = busy && stall && (take_bits(1) != 32'd0);
      dma_tfx_cancel = busy && (cyc == cancel_at);
      grant          = dma_en & ~cpu_en;
      rd_next        = grant & ~dir;
      rd_next_addr   = addr + 8'(grants);
      if (grant) begin
        if (dir)
          mem_model[addr + 8'(grants)][7:0] = data;
        grants++;
      end
      @(posedge mclk);
      #5;
      cpu_en = 1'b0;
      // Last grant or cancel ends the burst at this edge
      if (dma_tfx_cancel || grants == int'(count))
        busy = 1'b0;
      dma_tfx_cancel = 1'b0;
      check("dma_en", 16'(dma_en), 16'(busy));
      check("dma_busy", 16'(dma_busy), 16'(busy));
      cyc++;
    end
  endtask

  // ======================================================================
  // Directed tests
  // ======================================================================

  task automatic test_registers();
    logic [15:0] rd;
    logic [15:0] wd;
    for (int w = 0; w < 2; w++) begin
      per_read(CTRL_WORD + 14'(w), rd);
      check("per_dout", rd, 16'h0000);
    end
    // One lane per write with noise on the other lane
    for (int b = 0; b < 4; b++) begin
      wd = 16'(take_bits(16));
      // Start bit set while the count is still zero
      // The strobe must not read back
      if (b == 0)
        wd[0] = 1'b1;
      per_write(CTRL_WORD + 14'(b / 2), 2'(1 << (b % 2)), wd);
    end
    for (int w = 0; w < 2; w++) begin
      per_read(CTRL_WORD + 14'(w), rd);
      check("per_dout", rd, {reg_model[2*w+1], reg_model[2*w]});
    end
    // Neighbours of the block
    per_read(CTRL_WORD - 14'd1, rd);
    check("per_dout", rd, 16'h0000);
    per_read(CTRL_WORD + 14'd2, rd);
    check("per_dout", rd, 16'h0000);
    per_read(14'h3fff, rd);
    check("per_dout", rd, 16'h0000);
    per_write(CTRL_WORD, 2'b01, 16'h0000);
  endtask

  task automatic test_write_burst();
    logic [7:0] addr;
    logic [7:0] count;
    addr  = 8'(take_bits(8));
    count = 8'(take_bits(4)) + 8'd1;
    run_burst(1'b1, addr, 8'(take_bits(8)), count, 1'b0, -1);
    // One word past the end stays as filled
    verify_memory(addr, int'(count) + 1);
  endtask

  task automatic test_read_burst();
    logic [7:0] addr;
    addr = 8'(take_bits(8));
    for (int i = 0; i < 12; i++)
      cpu_write(addr + 8'(i), 16'(take_bits(16)));
    run_burst(1'b0, addr, 8'h00, 8'd12, 1'b0, -1);
  endtask

  task automatic test_contention();
    logic [7:0] addr;
    addr = 8'(take_bits(8));
    run_burst(1'b1, addr, 8'(take_bits(8)), 8'd20, 1'b1, -1);
    check("trace", trace, exp_trace);
    verify_memory(addr, 21);
    // Reads under stalls
    run_burst(1'b0, addr, 8'h00, 8'd20, 1'b1, -1);
  endtask

  task automatic test_cancel();
    logic [7:0] addr;
    addr = 8'(take_bits(8));
    run_burst(1'b1, addr, 8'(take_bits(8)), 8'd24, 1'b0, 7);
    verify_memory(addr, 24);
  endtask

  task automatic test_zero_count();
    run_burst(1'b1, 8'h10, 8'hff, 8'd0, 1'b0, -1);
    repeat (4) begin
      @(posedge mclk);
      #5;
      check("dma_en", 16'(dma_en), 16'h0000);
    end
    verify_memory(8'h10, 1);
  endtask

  // ======================================================================
  // Main sequence and watchdog
  // ======================================================================

  initial begin
    puc_rst        = 1'b1;
    per_addr       = 14'h0000;
    per_din        = 16'h0000;
    per_en         = 1'b0;
    per_we         = 2'b00;
    cpu_en         = 1'b0;
    cpu_addr       = 8'h00;
    cpu_we         = 2'b00;
    cpu_din        = 16'h0000;
    dma_tfx_cancel = 1'b0;
    lfsr           = 32'h1a14_f914;
    exp_trace      = 16'h0000;
    for (int i = 0; i < 4; i++)
      reg_model[i] = 8'h00;
    repeat (10) @(posedge mclk);
    #5;
    puc_rst = 1'b0;
    // Fill word from the whole address
    for (int a = 0; a < 256; a++)
      cpu_write(8'(a), {8'(a) ^ 8'h5a, ~8'(a)});
    test_registers();
    test_write_burst();
    test_read_burst();
    test_contention();
    test_cancel();
    test_zero_count();
    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * 100);
    $display("Watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

/* dma_probe_top.sv */
`timescale 1ns/1ps

module dma_probe_top (
  input  logic                               mclk,
  input  logic                               puc_rst,
  // Peripheral bus
  input  logic [13:0]                        per_addr,
  input  logic [15:0]                        per_din,
  input  logic                               per_en,
  input  logic [1:0]                         per_we,
  output logic [15:0]                        per_dout,
  // CPU port
  input  logic                               cpu_en,
  input  logic [dma_probe_pkg::DMEM_AW-1:0]  cpu_addr,
  input  logic [1:0]                         cpu_we,
  input  logic [15:0]                        cpu_din,
  output logic [15:0]                        cpu_dout,
  // DMA status
  input  logic                               dma_tfx_cancel,
  output logic                               dma_en,
  output logic                               dma_busy,
  output logic [7:0]                         dma_rdata,
  output logic [dma_probe_pkg::TRACE_W-1:0]  trace
);

  // ======================================================================
  // Interconnect
  // ======================================================================

  // Config from the register block
  logic                               cfg_dir;
  logic                               cfg_trace_run;
  logic [dma_probe_pkg::DMEM_AW-1:0]  cfg_addr;
  logic [7:0]                         cfg_data;
  logic [7:0]                         cfg_count;
  logic                               start;

  // DMA request side
  logic                               dma_ready;
  logic [dma_probe_pkg::DMEM_AW-1:0]  dma_addr;
  logic [1:0]                         dma_we;
  logic [15:0]                        dma_din;
  logic [15:0]                        dma_rdata_word;

  // Memory port
  logic                               mem_en;
  logic [dma_probe_pkg::DMEM_AW-1:0]  mem_addr;
  logic [1:0]                         mem_we;
  logic [15:0]                        mem_din;
  logic [15:0]                        mem_dout;
  logic                               mem_rd_owner;

  // Trace shift enable
  logic                               trace_run;

  assign trace_run      = dma_busy | cfg_trace_run;
  // Single memory output fanned to both sides
  assign cpu_dout       = mem_dout;
  assign dma_rdata_word = mem_dout & {16{mem_rd_owner}};

  // ======================================================================
  // Instances
  // ======================================================================

  dma_probe_regs u_regs (
    .mclk          (mclk),
    .puc_rst       (puc_rst),
    .per_addr      (per_addr),
    .per_din       (per_din),
    .per_en        (per_en),
    .per_we        (per_we),
    .per_dout      (per_dout),
    .cfg_dir       (cfg_dir),
    .cfg_trace_run (cfg_trace_run),
    .cfg_addr      (cfg_addr),
    .cfg_data      (cfg_data),
    .cfg_count     (cfg_count),
    .start         (start)
  );

  dma_probe_master u_master (
    .mclk           (mclk),
    .puc_rst        (puc_rst),
    .start          (start),
    .cfg_dir        (cfg_dir),
    .cfg_addr       (cfg_addr),
    .cfg_data       (cfg_data),
    .cfg_count      (cfg_count),
    .dma_ready      (dma_ready),
    .dma_tfx_cancel (dma_tfx_cancel),
    .dma_rdata_word (dma_rdata_word),
    .dma_en         (dma_en),
    .dma_addr       (dma_addr),
    .dma_we         (dma_we),
    .dma_din        (dma_din),
    .dma_busy       (dma_busy),
    .dma_rdata      (dma_rdata)
  );

  dmem_arbiter u_arb (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .cpu_en       (cpu_en),
    .cpu_addr     (cpu_addr),
    .cpu_we       (cpu_we),
    .cpu_din      (cpu_din),
    .dma_en       (dma_en),
    .dma_addr     (dma_addr),
    .dma_we       (dma_we),
    .dma_din      (dma_din),
    .dma_ready    (dma_ready),
    .mem_en       (mem_en),
    .mem_addr     (mem_addr),
    .mem_we       (mem_we),
    .mem_din      (mem_din),
    .mem_rd_owner (mem_rd_owner)
  );

  dmem_ram u_ram (
    .mclk     (mclk),
    .mem_en   (mem_en),
    .mem_addr (mem_addr),
    .mem_we   (mem_we),
    .mem_din  (mem_din),
    .mem_dout (mem_dout)
  );

  dma_probe_trace u_trace (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .run       (trace_run),
    .dma_ready (dma_ready),
    .trace     (trace)
  );

endmodule

/* dma_probe_regs.sv */
`timescale 1ns/1ps

module dma_probe_regs (
  input  logic                               mclk,
  input  logic                               puc_rst,
  // Peripheral bus
  input  logic [13:0]                        per_addr,
  input  logic [15:0]                        per_din,
  input  logic                               per_en,
  input  logic [1:0]                         per_we,
  output logic [15:0]                        per_dout,
  // Configuration levels to the DMA master and trace
  output logic                               cfg_dir,
  output logic                               cfg_trace_run,
  output logic [dma_probe_pkg::DMEM_AW-1:0]  cfg_addr,
  output logic [7:0]                         cfg_data,
  output logic [7:0]                         cfg_count,
  output logic                               start
);

  // ======================================================================
  // Address decoder
  // ======================================================================

  // Block hit on the word address
  logic                              reg_sel;
  // Word inside the block
  logic [dma_probe_pkg::DEC_WD-2:0]  word_idx;
  // Block read with no lane written
  logic                              reg_read;

  // Per-byte strobes and lane data
  logic [dma_probe_pkg::NREG-1:0]    byte_wr;
  logic [dma_probe_pkg::NREG-1:0]    byte_rd;
  logic [7:0]                        byte_nxt [dma_probe_pkg::NREG];

  // Control bytes
  logic [7:0]                        cntrl [dma_probe_pkg::NREG];

  // Word address against the byte base from bit 1 up
  assign reg_sel  = per_en &
                    (per_addr[13:dma_probe_pkg::DEC_WD-1] ==
                     dma_probe_pkg::BASE_ADDR[14:dma_probe_pkg::DEC_WD]);
  assign word_idx = per_addr[dma_probe_pkg::DEC_WD-2:0];
  assign reg_read = reg_sel & ~|per_we;

  // ======================================================================
  // Control byte registers
  // ======================================================================

  for (genvar i = 0; i < dma_probe_pkg::NREG; i++) begin : g_byte
    // Word match for this byte
    logic word_hit;

    assign word_hit    = (word_idx == (dma_probe_pkg::DEC_WD-1)'(i >> 1));
    // Even offsets on the low lane
    assign byte_nxt[i] = per_din[8*(i%2) +: 8];
    assign byte_wr[i]  = reg_sel & word_hit & per_we[i%2];
    assign byte_rd[i]  = reg_read & word_hit;

    always_ff @(posedge mclk or posedge puc_rst) begin
      if (puc_rst) begin
        cntrl[i] <= 8'h00;
      end else if (byte_wr[i]) begin
        // Start strobe never lands in CNTRL1
        if (i == int'(dma_probe_pkg::CNTRL1))
          cntrl[i] <= byte_nxt[i] & ~(8'h01 << dma_probe_pkg::CTL_START);
        else
          cntrl[i] <= byte_nxt[i];
      end
    end
  end

  // One-cycle start pulse after the CNTRL1 write
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      start <= 1'b0;
    end else begin
      start <= byte_wr[dma_probe_pkg::CNTRL1] &
               byte_nxt[dma_probe_pkg::CNTRL1][dma_probe_pkg::CTL_START];
    end
  end

  // Config levels
  assign cfg_dir       = cntrl[dma_probe_pkg::CNTRL1][dma_probe_pkg::CTL_DIR];
  assign cfg_trace_run = cntrl[dma_probe_pkg::CNTRL1][dma_probe_pkg::CTL_TRACE];
  assign cfg_addr      = cntrl[dma_probe_pkg::CNTRL2];
  assign cfg_data      = cntrl[dma_probe_pkg::CNTRL3];
  assign cfg_count     = cntrl[dma_probe_pkg::CNTRL4];

  // ======================================================================
  // Read data
  // ======================================================================

  // Masked bytes ORed onto their lanes
  // Zero when the block is not selected
  always_comb begin
    per_dout = 16'h0000;
    for (int i = 0; i < dma_probe_pkg::NREG; i++) begin
      if (byte_rd[i])
        per_dout[8*(i%2) +: 8] = per_dout[8*(i%2) +: 8] | cntrl[i];
    end
  end

endmodule

/* dma_probe_master.sv */
`timescale 1ns/1ps

module dma_probe_master (
  input  logic                               mclk,
  input  logic                               puc_rst,
  // Burst setup
  input  logic                               start,
  input  logic                               cfg_dir,
  input  logic [dma_probe_pkg::DMEM_AW-1:0]  cfg_addr,
  input  logic [7:0]                         cfg_data,
  input  logic [7:0]                         cfg_count,
  // Grant and cancel
  input  logic                               dma_ready,
  input  logic                               dma_tfx_cancel,
  // Registered memory word
  input  logic [15:0]                        dma_rdata_word,
  // Memory request
  output logic                               dma_en,
  output logic [dma_probe_pkg::DMEM_AW-1:0]  dma_addr,
  output logic [1:0]                         dma_we,
  output logic [15:0]                        dma_din,
  // Status and read data
  output logic                               dma_busy,
  output logic [7:0]                         dma_rdata
);

  // Granted transfer this cycle
  logic        xfer;
  // Final byte of the burst
  logic        last_byte;
  // Bytes still to move
  logic [7:0]  remain;
  // Granted read waiting for memory data
  logic        rd_pend;
  // Write byte latched at start
  logic [7:0]  wr_byte;

  assign xfer      = dma_en & dma_ready;
  assign last_byte = (remain == 8'd1);

  // Writes only touch the low lane
  assign dma_din   = {8'h00, wr_byte};

  // ======================================================================
  // Burst control
  // ======================================================================

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      dma_en   <= 1'b0;
      dma_busy <= 1'b0;
      dma_we   <= 2'b00;
      dma_addr <= '0;
      remain   <= 8'd0;
    end else if (dma_en) begin
      // Cancel or last grant ends the burst
      if (dma_tfx_cancel || (xfer && last_byte)) begin
        dma_en   <= 1'b0;
        dma_busy <= 1'b0;
        dma_we   <= 2'b00;
      end
      // Advance only when granted
      // Request held while stalled
      if (xfer) begin
        dma_addr <= dma_addr + (dma_probe_pkg::DMEM_AW)'(1);
        remain   <= remain - 8'd1;
      end
    end else if (start && (cfg_count != 8'd0)) begin
      // Zero count never raises a request
      dma_en   <= 1'b1;
      dma_busy <= 1'b1;
      dma_we   <= {1'b0, cfg_dir};
      dma_addr <= cfg_addr;
      remain   <= cfg_count;
    end
  end

  // Write byte for the whole burst
  always_ff @(posedge mclk) begin
    if (start && !dma_en)
      wr_byte <= cfg_data;
  end

  // ======================================================================
  // Read capture
  // ======================================================================

  // Flag a granted read for the next cycle
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      rd_pend <= 1'b0;
    else
      rd_pend <= xfer & ~|dma_we;
  end

  // Low byte of the word
  always_ff @(posedge mclk) begin
    if (rd_pend)
      dma_rdata <= dma_rdata_word[7:0];
  end

endmodule

/* dmem_arbiter.sv */
`timescale 1ns/1ps

module dmem_arbiter (
  input  logic                               mclk,
  input  logic                               puc_rst,
  // CPU port
  input  logic                               cpu_en,
  input  logic [dma_probe_pkg::DMEM_AW-1:0]  cpu_addr,
  input  logic [1:0]                         cpu_we,
  input  logic [15:0]                        cpu_din,
  // DMA port
  input  logic                               dma_en,
  input  logic [dma_probe_pkg::DMEM_AW-1:0]  dma_addr,
  input  logic [1:0]                         dma_we,
  input  logic [15:0]                        dma_din,
  output logic                               dma_ready,
  // Memory port
  output logic                               mem_en,
  output logic [dma_probe_pkg::DMEM_AW-1:0]  mem_addr,
  output logic [1:0]                         mem_we,
  output logic [15:0]                        mem_din,
  // DMA owned the last memory read
  output logic                               mem_rd_owner
);

  // DMA wins this cycle
  logic dma_win;
  // Memory read this cycle
  logic mem_read;

  // ======================================================================
  // Fixed priority grant
  // ======================================================================

  // CPU always first
  assign dma_win   = dma_en & ~cpu_en;
  assign dma_ready = dma_win;

  // ======================================================================
  // Memory port mux
  // ======================================================================

  always_comb begin
    mem_en = cpu_en | dma_en;
    if (cpu_en) begin
      mem_addr = cpu_addr;
      mem_we   = cpu_we;
      mem_din  = cpu_din;
    end else begin
      mem_addr = dma_addr;
      mem_we   = dma_we;
      mem_din  = dma_din;
    end
  end

  assign mem_read = mem_en & ~|mem_we;

  // ======================================================================
  // Read owner
  // ======================================================================

  // Tags the registered memory output in the next cycle
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      mem_rd_owner <= 1'b0;
    else if (mem_read)
      mem_rd_owner <= dma_win;
  end

endmodule

/* dma_probe_trace.sv */
`timescale 1ns/1ps

module dma_probe_trace (
  input  logic                               mclk,
  input  logic                               puc_rst,
  // Shift enable
  input  logic                               run,
  // Grant of the current cycle
  input  logic                               dma_ready,
  output logic [dma_probe_pkg::TRACE_W-1:0]  trace
);

  // Newest grant in bit 0
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      trace <= '0;
    else if (run)
      trace <= {trace[dma_probe_pkg::TRACE_W-2:0], dma_ready};
  end

endmodule

/* dmem_ram.sv */
`timescale 1ns/1ps

module dmem_ram (
  input  logic                               mclk,
  input  logic                               mem_en,
  input  logic [dma_probe_pkg::DMEM_AW-1:0]  mem_addr,
  input  logic [1:0]                         mem_we,
  input  logic [15:0]                        mem_din,
  output logic [15:0]                        mem_dout
);

  // Word array
  logic [15:0] mem [dma_probe_pkg::DMEM_DEPTH];

  // Byte lane writes and registered read
  always_ff @(posedge mclk) begin
    if (mem_en) begin
      if (mem_we[0])
        mem[mem_addr][7:0] <= mem_din[7:0];
      if (mem_we[1])
        mem[mem_addr][15:8] <= mem_din[15:8];
      // Old word on a write cycle
      mem_dout <= mem[mem_addr];
    end
  end

endmodule

/* dma_probe_pkg.sv */
package dma_probe_pkg;

  // ======================================================================
  // Peripheral register map
  // ======================================================================

  // Byte base of the register block
  localparam logic [14:0] BASE_ADDR = 15'h0250;

  // Address bits covered by the block decoder
  localparam int DEC_WD = 2;

  // Number of byte registers in the block
  localparam int NREG = 1 << DEC_WD;

  // Byte offsets inside the block
  localparam logic [DEC_WD-1:0] CNTRL1 = 2'd0;
  localparam logic [DEC_WD-1:0] CNTRL2 = 2'd1;
  localparam logic [DEC_WD-1:0] CNTRL3 = 2'd2;
  localparam logic [DEC_WD-1:0] CNTRL4 = 2'd3;

  // CNTRL1 bit positions
  // Start is a write-only strobe
  localparam int CTL_START = 0;
  // Transfer direction, 1 means write to memory
  localparam int CTL_DIR = 1;
  // Trace keeps shifting while idle
  localparam int CTL_TRACE = 2;

  // ======================================================================
  // Data memory and trace
  // ======================================================================

  // Word address width of the data memory
  localparam int DMEM_AW = 8;

  // Word count of the data memory
  localparam int DMEM_DEPTH = 1 << DMEM_AW;

  // Grant history length
  localparam int TRACE_W = 16;

endpackage
